// File: verilog/fb_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frontend memory bus definitions
//   data and address widths
//   exception codes carried on commands and replies
//   command (A channel) and response (B channel) payload structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fb_bus_pkg;

   // Bus widths
   localparam int fb_dw = 32;
   localparam int fb_aw = 32;

   // Exception codes
   // bus_err comes from the register block, the faults come from the master
   typedef enum logic [1:0]
   {
      exc_none        = 2'd0,
      exc_bus_err     = 2'd1,
      exc_fetch_fault = 2'd2,
      exc_page_fault  = 2'd3
   } fb_exc_t;

   // A channel payload, 70 bits
   // Nonzero wmsk marks a write
   typedef struct packed
   {
      logic [fb_aw-1:0]   addr;
      logic [fb_dw-1:0]   wdata;
      logic [fb_dw/8-1:0] wmsk;
      fb_exc_t            exc;
   } fb_cmd_t;

   // B channel payload, 34 bits
   typedef struct packed
   {
      logic [fb_dw-1:0] rdata;
      fb_exc_t          exc;
   } fb_rsp_t;

endpackage

// File: verilog/fb_map_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fabric address map
//   region and offset split of the address word
//   RAM and register window bases, bus select indices
//   address union, read raw or as region and offset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fb_map_pkg;

   // Address split, 20 region bits over a 4 KB offset
   localparam int fb_region_bits = 20;
   localparam int fb_offset_bits = 12;

   // Window bases
   localparam logic [fb_region_bits+fb_offset_bits-1:0] fb_ram_base = 32'h0000_0000;
   localparam logic [fb_region_bits+fb_offset_bits-1:0] fb_reg_base = 32'h0000_1000;

   // Region numbers of the two windows
   localparam logic [fb_region_bits-1:0] fb_ram_region = fb_ram_base[fb_offset_bits +: fb_region_bits];
   localparam logic [fb_region_bits-1:0] fb_reg_region = fb_reg_base[fb_offset_bits +: fb_region_bits];

   // Scratch registers implemented in the register window
   localparam int fb_reg_count = 4;

   // Bus select bit of each slave
   localparam int fb_sel_ram = 0;
   localparam int fb_sel_reg = 1;

   typedef struct packed
   {
      logic [fb_region_bits-1:0] region;
      logic [fb_offset_bits-1:0] offset;
   } fb_addr_fields_t;

   typedef union packed
   {
      logic [fb_region_bits+fb_offset_bits-1:0] raw;
      fb_addr_fields_t                           fields;
   } fb_addr_u;

endpackage

// File: verilog/fb_addr_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address decoder (decode stage)
//   region compare against the RAM window
//   one-hot bus select, register bus takes every other region
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module fb_addr_decode
   import fb_map_pkg::*;
#(
   parameter int n_bus = 2
)
(
   input  fb_addr_u         addr,
   output logic [n_bus-1:0] bus_sel
);

   logic ram_hit;

   // Only region 0 goes to the RAM
   assign ram_hit = (addr.fields.region == fb_ram_region);

   always_comb
   begin
      bus_sel = '0;
      bus_sel[fb_sel_ram] = ram_hit;
      // Register block also answers the unmapped regions
      bus_sel[fb_sel_reg] = ~ram_hit;
   end

endmodule

// File: verilog/fb_router.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command router (execute stage)
//   per-bus pending flags, set by command and cleared by reply
//   exclusive command acceptance and a_ready
//   command fan-out to every bus
//   assertions on pending exclusivity and master payload stability
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module fb_router
   import fb_bus_pkg::*;
#(
   parameter int n_bus = 2
)
(
   input                    clk,
   input                    reset,
   // Frontend command channel
   input  logic             a_valid,
   output logic             a_ready,
   input  fb_cmd_t          a_cmd,
   // Decoded target
   input  logic [n_bus-1:0] bus_sel,
   // Slave side
   output logic [n_bus-1:0] bus_a_valid,
   input  logic [n_bus-1:0] bus_a_ready,
   output fb_cmd_t          bus_cmd,
   // Reply handshakes from the merger
   input  logic [n_bus-1:0] bus_b_done,
   output logic [n_bus-1:0] bus_pending
);

   logic [n_bus-1:0] accept;
   logic [n_bus-1:0] cmd_done;
   logic [n_bus-1:0] sel_ready;

   always_comb
   begin
      for (int i = 0; i < n_bus; i++)
      begin
         // Free fabric, or more work for the bus already in use
         accept[i] = ~|bus_pending | bus_pending[i];
         // Valid is never derived from the slave's ready
         bus_a_valid[i] = a_valid & bus_sel[i] & accept[i];
         sel_ready[i] = bus_sel[i] & accept[i] & bus_a_ready[i];
         cmd_done[i] = bus_a_valid[i] & bus_a_ready[i];
      end
   end

   assign a_ready = |sel_ready;

   // Same payload to every bus, valid picks the one
   assign bus_cmd = a_cmd;

   // Pending flags
   // A new command keeps the flag up even if a reply leaves this cycle
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         bus_pending <= '0;
      end
      else
      begin
         for (int i = 0; i < n_bus; i++)
         begin
            if (cmd_done[i])
            begin
               bus_pending[i] <= 1'b1;
            end
            else if (bus_b_done[i])
            begin
               bus_pending[i] <= 1'b0;
            end
         end
      end
   end

   // Only one bus may own the reply path,
   // this is what keeps replies in command order
   assert property (@(posedge clk) disable iff (reset)
      $onehot0(bus_pending))
   else $error("more than one bus pending: %b", bus_pending);

   // Master keeps an offered command until it is taken
   assert property (@(posedge clk) disable iff (reset)
      a_valid && !a_ready |=> a_valid && $stable(a_cmd))
   else $error("command dropped or changed before acceptance");

endmodule

// File: verilog/fb_resp_merge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response merger (result stage)
//   AND-OR merge of the pending bus's reply onto the B channel
//   ready steering back to the pending bus, reply-done flags
//   assertion that only the pending bus raises valid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module fb_resp_merge
   import fb_bus_pkg::*;
#(
   parameter int n_bus = 2
)
(
   input                             clk,
   input                             reset,
   input  logic [n_bus-1:0]          bus_pending,
   // Slave replies
   input  logic [n_bus-1:0]          bus_b_valid,
   output logic [n_bus-1:0]          bus_b_ready,
   input  fb_rsp_t [n_bus-1:0]       bus_rsp,
   // Frontend response channel
   output logic                      b_valid,
   input  logic                      b_ready,
   output fb_rsp_t                   b_rsp,
   // Reply handshake per bus, for the router
   output logic [n_bus-1:0]          bus_b_done
);

   localparam int rsp_w = $bits(fb_rsp_t);

   logic [rsp_w-1:0] rsp_or;

   always_comb
   begin
      b_valid = 1'b0;
      rsp_or = '0;
      for (int i = 0; i < n_bus; i++)
      begin
         // Non-pending buses contribute zeros
         b_valid = b_valid | (bus_pending[i] & bus_b_valid[i]);
         rsp_or = rsp_or | ({rsp_w{bus_pending[i]}} & bus_rsp[i]);
      end
   end

   assign b_rsp = fb_rsp_t'(rsp_or);

   // Ready only to the owner of the reply path
   assign bus_b_ready = {n_bus{b_ready}} & bus_pending;
   assign bus_b_done = bus_b_ready & bus_b_valid;

   // An idle bus with a reply would be a slave out of step with the router
   assert property (@(posedge clk) disable iff (reset)
      (bus_b_valid & ~bus_pending) == '0)
   else $error("reply from non-pending bus: valid %b pending %b", bus_b_valid, bus_pending);

endmodule

// File: verilog/fb_ram_slave.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RAM slave
//   4 KB word memory with byte-masked writes
//   one-cycle reply, held until taken
//   accepts a new command as the held reply leaves
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module fb_ram_slave
   import fb_bus_pkg::*;
   import fb_map_pkg::*;
(
   input           clk,
   input           reset,
   // Command channel
   input  logic    a_valid,
   output logic    a_ready,
   input  fb_cmd_t a_cmd,
   // Response channel
   output logic    b_valid,
   input  logic    b_ready,
   output fb_rsp_t b_rsp
);

   localparam int words = (1 << fb_offset_bits) / (fb_dw / 8);

   logic [fb_dw-1:0]         mem [words];
   fb_addr_u                 addr;
   logic [$clog2(words)-1:0] idx;
   logic                     cmd_done;
   logic                     rsp_done;

   // Word index from the offset field
   assign addr = a_cmd.addr;
   assign idx = addr.fields.offset[fb_offset_bits-1:2];

   // Room for a command when the reply slot is empty or emptying
   assign a_ready = ~b_valid | b_ready;
   assign cmd_done = a_valid & a_ready;
   assign rsp_done = b_valid & b_ready;

   // Memory array and reply payload
   always_ff @(posedge clk)
   begin
      if (cmd_done)
      begin
         // Faulted commands never touch memory
         if (a_cmd.exc == exc_none)
         begin
            for (int b = 0; b < fb_dw / 8; b++)
            begin
               if (a_cmd.wmsk[b])
               begin
                  mem[idx][8*b +: 8] <= a_cmd.wdata[8*b +: 8];
               end
            end
         end
         // Old word goes back for writes too
         b_rsp.rdata <= mem[idx];
         b_rsp.exc <= a_cmd.exc;
      end
   end

   // Reply valid
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         b_valid <= 1'b0;
      end
      else if (cmd_done)
      begin
         b_valid <= 1'b1;
      end
      else if (rsp_done)
      begin
         b_valid <= 1'b0;
      end
   end

endmodule

// File: verilog/fb_reg_slave.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register block slave
//   scratch registers with byte-masked writes
//   wait-state counter delaying each reply by reg_wait cycles
//   bus_err reply for unmapped offsets and regions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module fb_reg_slave
   import fb_bus_pkg::*;
   import fb_map_pkg::*;
#(
   parameter int reg_wait = 2
)
(
   input           clk,
   input           reset,
   // Command channel
   input  logic    a_valid,
   output logic    a_ready,
   input  fb_cmd_t a_cmd,
   // Response channel
   output logic    b_valid,
   input  logic    b_ready,
   output fb_rsp_t b_rsp
);

   localparam int cnt_w = (reg_wait > 0) ? $clog2(reg_wait + 1) : 1;
   localparam int idx_w = (fb_reg_count > 1) ? $clog2(fb_reg_count) : 1;

   logic [fb_dw-1:0] regs [fb_reg_count];
   fb_addr_u         addr;
   logic [idx_w-1:0] idx;
   logic             hit;
   logic             busy;
   logic [cnt_w-1:0] wait_cnt;
   logic             cmd_done;
   logic             rsp_done;

   assign addr = a_cmd.addr;
   assign idx = addr.fields.offset[2 +: idx_w];
   // Implemented words sit at the bottom of the register window
   assign hit = (addr.fields.region == fb_reg_region) &&
                (addr.fields.offset < fb_offset_bits'(fb_reg_count * 4));

   // One command at a time
   assign a_ready = ~busy;
   assign cmd_done = a_valid & a_ready;
   assign rsp_done = b_valid & b_ready;

   // Scratch registers and reply payload
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int r = 0; r < fb_reg_count; r++)
         begin
            regs[r] <= '0;
         end
      end
      else if (cmd_done)
      begin
         if (hit && a_cmd.exc == exc_none)
         begin
            for (int b = 0; b < fb_dw / 8; b++)
            begin
               if (a_cmd.wmsk[b])
               begin
                  regs[idx][8*b +: 8] <= a_cmd.wdata[8*b +: 8];
               end
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (cmd_done)
      begin
         b_rsp.rdata <= hit ? regs[idx] : '0;
         // Master's own fault beats bus_err
         if (a_cmd.exc != exc_none)
            b_rsp.exc <= a_cmd.exc;
         else
            b_rsp.exc <= hit ? exc_none : exc_bus_err;
      end
   end

   // Busy from acceptance to reply handshake
   // Counter runs down before valid rises
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy <= 1'b0;
         b_valid <= 1'b0;
         wait_cnt <= '0;
      end
      else if (cmd_done)
      begin
         busy <= 1'b1;
         wait_cnt <= cnt_w'(reg_wait);
      end
      else if (rsp_done)
      begin
         busy <= 1'b0;
         b_valid <= 1'b0;
      end
      else if (busy && !b_valid)
      begin
         if (wait_cnt == '0)
            b_valid <= 1'b1;
         else
            wait_cnt <= wait_cnt - 1'b1;
      end
   end

endmodule

// File: verilog/fb_fabric_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frontend bus fabric top level
//   address decoder, router and response merger
//   RAM slave and register block slave
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module fb_fabric_top
   import fb_bus_pkg::*;
   import fb_map_pkg::*;
#(
   parameter int n_bus    = 2,
   parameter int reg_wait = 2
)
(
   input           clk,
   input           reset,
   // Command channel
   input  logic    a_valid,
   output logic    a_ready,
   input  fb_cmd_t a_cmd,
   // Response channel
   output logic    b_valid,
   input  logic    b_ready,
   output fb_rsp_t b_rsp
);

   logic [n_bus-1:0]    bus_sel;
   logic [n_bus-1:0]    bus_a_valid;
   logic [n_bus-1:0]    bus_a_ready;
   fb_cmd_t             bus_cmd;
   logic [n_bus-1:0]    bus_pending;
   logic [n_bus-1:0]    bus_b_valid;
   logic [n_bus-1:0]    bus_b_ready;
   logic [n_bus-1:0]    bus_b_done;
   fb_rsp_t [n_bus-1:0] bus_rsp;

   fb_addr_decode #(.n_bus(n_bus)) i_fb_addr_decode
   (
      .addr    (a_cmd.addr),
      .bus_sel (bus_sel)
   );

   fb_router #(.n_bus(n_bus)) i_fb_router
   (
      .clk         (clk),
      .reset       (reset),
      .a_valid     (a_valid),
      .a_ready     (a_ready),
      .a_cmd       (a_cmd),
      .bus_sel     (bus_sel),
      .bus_a_valid (bus_a_valid),
      .bus_a_ready (bus_a_ready),
      .bus_cmd     (bus_cmd),
      .bus_b_done  (bus_b_done),
      .bus_pending (bus_pending)
   );

   fb_resp_merge #(.n_bus(n_bus)) i_fb_resp_merge
   (
      .clk         (clk),
      .reset       (reset),
      .bus_pending (bus_pending),
      .bus_b_valid (bus_b_valid),
      .bus_b_ready (bus_b_ready),
      .bus_rsp     (bus_rsp),
      .b_valid     (b_valid),
      .b_ready     (b_ready),
      .b_rsp       (b_rsp),
      .bus_b_done  (bus_b_done)
   );

   // RAM on bus 0
   fb_ram_slave i_fb_ram_slave
   (
      .clk     (clk),
      .reset   (reset),
      .a_valid (bus_a_valid[fb_sel_ram]),
      .a_ready (bus_a_ready[fb_sel_ram]),
      .a_cmd   (bus_cmd),
      .b_valid (bus_b_valid[fb_sel_ram]),
      .b_ready (bus_b_ready[fb_sel_ram]),
      .b_rsp   (bus_rsp[fb_sel_ram])
   );

   // Register block on bus 1
   fb_reg_slave #(.reg_wait(reg_wait)) i_fb_reg_slave
   (
      .clk     (clk),
      .reset   (reset),
      .a_valid (bus_a_valid[fb_sel_reg]),
      .a_ready (bus_a_ready[fb_sel_reg]),
      .a_cmd   (bus_cmd),
      .b_valid (bus_b_valid[fb_sel_reg]),
      .b_ready (bus_b_ready[fb_sel_reg]),
      .b_rsp   (bus_rsp[fb_sel_reg])
   );

endmodule

// File: tests/fb_ref_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of the fabric
//   RAM words with known flags, scratch registers
//   expected-reply queue in command order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef FB_REF_MODEL_SVH
`define FB_REF_MODEL_SVH

   // Expected reply
   // rdata compare skipped while the RAM word is still unknown
   typedef struct packed
   {
      fb_rsp_t rsp;
      logic    chk_data;
   } exp_rsp_t;

   logic [31:0] ram_model [ram_words];
   logic        ram_known [ram_words];
   logic [31:0] reg_model [fb_reg_count];
   exp_rsp_t    exp_q [$];

   // Masked byte update, mask widened to a bit mask
   function automatic logic [31:0] apply_mask(input logic [31:0] old_word,
                                              input logic [31:0] wdata,
                                              input logic [3:0]  wmsk);
      logic [31:0] bit_mask;
      bit_mask = {{8{wmsk[3]}}, {8{wmsk[2]}}, {8{wmsk[1]}}, {8{wmsk[0]}}};
      return (old_word & ~bit_mask) | (wdata & bit_mask);
   endfunction

   // Accepted command into the model, expected reply onto the queue
   task automatic model_cmd(input fb_cmd_t cmd);
      fb_addr_u a;
      exp_rsp_t e;
      logic     hit;
      int       w;
      a = cmd.addr;
      e.chk_data = 1'b1;
      e.rsp.exc = cmd.exc;
      if (a.fields.region == 20'd0)
      begin
         // RAM, old word back on every reply
         w = int'(a.fields.offset[7:2]);
         e.rsp.rdata = ram_model[w];
         e.chk_data = ram_known[w];
         if (cmd.exc == exc_none)
         begin
            ram_model[w] = apply_mask(ram_model[w], cmd.wdata, cmd.wmsk);
            ram_known[w] = ram_known[w] | (cmd.wmsk == 4'hf);
         end
      end
      else
      begin
         // Register window is region 1, first 16 bytes implemented
         hit = (a.fields.region == 20'd1) && (a.fields.offset < 12'd16);
         w = int'(a.fields.offset[3:2]);
         e.rsp.rdata = hit ? reg_model[w] : 32'h0;
         if (cmd.exc == exc_none && !hit)
            e.rsp.exc = exc_bus_err;
         if (cmd.exc == exc_none && hit)
            reg_model[w] = apply_mask(reg_model[w], cmd.wdata, cmd.wmsk);
      end
      n_cmd_acc++;
      exp_q.push_back(e);
   endtask

`endif

// File: tests/fb_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the frontend bus fabric
//   clock, reset, seeded random commands and back-pressure
//   reply checks against the reference model
//   per-test lines, summary and cycle limit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module fb_tb
   import fb_bus_pkg::*;
   import fb_map_pkg::*;
();

   // RAM words touched by the tests
   localparam int ram_words = 64;
   localparam int n_ram = 200;
   localparam int n_reg = 120;
   localparam int n_exc = 60;
   localparam int n_mix = 300;
   localparam int n_back = ram_words + fb_reg_count;
   localparam int n_total = ram_words + n_ram + n_reg + n_exc + n_back + n_mix;
   localparam int cycle_limit = 8 * n_total + 200;

   logic    clk;
   logic    reset;
   logic    a_valid;
   logic    a_ready;
   fb_cmd_t a_cmd;
   logic    b_valid;
   logic    b_ready;
   fb_rsp_t b_rsp;

   // Precomputed ready pattern, compared against the stall level
   logic [7:0] rdy_rand [1024];
   logic [7:0] stall_lvl = 8'd64;

   int errors = 0;
   int checks = 0;
   int n_tests = 0;
   int n_cmd_acc = 0;
   int n_rsp = 0;
   int cycles = 0;

`include "fb_ref_model.svh"

   fb_fabric_top i_fb_fabric_top
   (
      .clk     (clk),
      .reset   (reset),
      .a_valid (a_valid),
      .a_ready (a_ready),
      .a_cmd   (a_cmd),
      .b_valid (b_valid),
      .b_ready (b_ready),
      .b_rsp   (b_rsp)
   );

   task automatic report_value(input string name, input logic [31:0] want, got);
      errors++;
      $display("[FAIL] %s expected %h got %h at %0t", name, want, got, $time);
   endtask

   // Reply against the head of the queue
   task automatic check_rsp(input fb_rsp_t got);
      exp_rsp_t e;
      n_rsp++;
      checks++;
      assert (exp_q.size() != 0)
      else
      begin
         errors++;
         $display("ERROR: reply arrived with no command outstanding at %0t", $time);
      end
      if (exp_q.size() != 0)
      begin
         e = exp_q.pop_front();
         if (e.chk_data)
         begin
            checks++;
            assert (got.rdata === e.rsp.rdata)
            else report_value("b_rsp.rdata", e.rsp.rdata, got.rdata);
         end
         checks++;
         assert (got.exc === e.rsp.exc)
         else report_value("b_rsp.exc", 32'(e.rsp.exc), 32'(got.exc));
      end
   endtask

   // Random RAM access in the low 64 words, zero mask reads
   function automatic fb_cmd_t ram_cmd();
      fb_cmd_t c;
      c.addr = {20'h0, 4'h0, 6'($urandom), 2'b00};
      c.wdata = $urandom;
      c.wmsk = 4'($urandom);
      c.exc = exc_none;
      return c;
   endfunction

   // Scratch registers, unmapped offsets and foreign regions
   function automatic fb_cmd_t reg_cmd();
      fb_cmd_t c;
      int      kind;
      c = ram_cmd();
      kind = int'($urandom % 8);
      if (kind < 5)
         c.addr = {20'h1, 8'h0, 2'($urandom), 2'b00};
      else if (kind < 7)
         c.addr = {20'h1, 12'($urandom) | 12'h010};
      else
         c.addr = {20'($urandom) | 20'h2, 12'($urandom)};
      return c;
   endfunction

   // Either target with a master fault attached
   function automatic fb_cmd_t exc_cmd();
      fb_cmd_t c;
      c = ($urandom % 2 == 0) ? ram_cmd() : reg_cmd();
      c.exc = ($urandom % 2 == 0) ? exc_fetch_fault : exc_page_fault;
      return c;
   endfunction

   function automatic fb_cmd_t mix_cmd();
      int kind;
      kind = int'($urandom % 8);
      if (kind == 0)
         return exc_cmd();
      else if (kind < 4)
         return reg_cmd();
      return ram_cmd();
   endfunction

   // Full-word write of RAM word i, makes the model word known
   function automatic fb_cmd_t fill_cmd(input int i);
      fb_cmd_t c;
      c.addr = {20'h0, 4'h0, 6'(i), 2'b00};
      c.wdata = $urandom;
      c.wmsk = 4'hf;
      c.exc = exc_none;
      return c;
   endfunction

   // Plain read of every RAM word, then every scratch register
   function automatic fb_cmd_t readback_cmd(input int i);
      fb_cmd_t c;
      c = fill_cmd(0);
      c.wmsk = 4'h0;
      if (i < ram_words)
         c.addr = {20'h0, 4'h0, 6'(i), 2'b00};
      else
         c.addr = {20'h1, 8'h0, 2'(i - ram_words), 2'b00};
      return c;
   endfunction

   // Offer a command and hold it until taken
   task automatic send_cmd(input fb_cmd_t cmd);
      if ($urandom % 4 == 0)
      begin
         a_valid <= 1'b0;
         @(posedge clk);
      end
      a_valid <= 1'b1;
      a_cmd <= cmd;
      @(posedge clk);
      while (!a_ready)
         @(posedge clk);
   endtask

   // Wait for every expected reply
   task automatic drain();
      a_valid <= 1'b0;
      do
         @(negedge clk);
      while (exp_q.size() != 0);
      @(posedge clk);
   endtask

   // kind: 0 fill, 1 RAM, 2 registers, 3 faults, 4 readback, else mixed
   task automatic run_test(input string name, input int kind, input int count);
      int err0;
      err0 = errors;
      for (int i = 0; i < count; i++)
      begin
         case (kind)
            0: send_cmd(fill_cmd(i));
            1: send_cmd(ram_cmd());
            2: send_cmd(reg_cmd());
            3: send_cmd(exc_cmd());
            4: send_cmd(readback_cmd(i));
            default: send_cmd(mix_cmd());
         endcase
      end
      drain();
      n_tests++;
      $display("test %s: %0d commands, %0d errors", name, count, errors - err0);
   endtask

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Back-pressure and cycle limit
   always @(posedge clk)
   begin
      b_ready <= (rdy_rand[cycles[9:0]] >= stall_lvl);
      cycles = cycles + 1;
      if (cycles >= cycle_limit)
      begin
         $display("ERROR: cycle limit %0d reached, %0d replies outstanding",
                  cycle_limit, exp_q.size());
         $display("Something failed");
         $finish;
      end
   end

   // Monitor, reply popped before the new command is pushed
   always @(posedge clk)
   begin
      if (!reset)
      begin
         if (b_valid && b_ready)
            check_rsp(b_rsp);
         if (a_valid && a_ready)
            model_cmd(a_cmd);
      end
   end

   initial
   begin
      void'($urandom(32'h11e2_fff3));
      for (int i = 0; i < 1024; i++)
         rdy_rand[i] = 8'($urandom);
      for (int i = 0; i < ram_words; i++)
      begin
         ram_model[i] = 32'h0;
         ram_known[i] = 1'b0;
      end
      // Registers come out of reset as zero
      for (int i = 0; i < fb_reg_count; i++)
         reg_model[i] = 32'h0;
      reset = 1'b1;
      a_valid = 1'b0;
      // Address 0 is RAM-bound
      a_cmd = '0;
      b_ready = 1'b0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);

      // Idle fabric right after reset
      checks += 2;
      assert (b_valid === 1'b0)
      else report_value("b_valid", 32'h0, 32'(b_valid));
      assert (a_ready === 1'b1)
      else report_value("a_ready", 32'h1, 32'(a_ready));
      n_tests++;
      $display("test reset_state: 0 commands, %0d errors", errors);

      run_test("ram_fill", 0, ram_words);
      run_test("ram_rw", 1, n_ram);
      run_test("reg_block", 2, n_reg);
      run_test("exc_pass", 3, n_exc);
      run_test("readback", 4, n_back);
      // Heavier back-pressure for the ordering test
      stall_lvl = 8'd128;
      run_test("mixed_order", 5, n_mix);

      checks++;
      assert (n_rsp == n_cmd_acc && exp_q.size() == 0)
      else
      begin
         errors++;
         $display("ERROR: %0d commands accepted but %0d replies seen", n_cmd_acc, n_rsp);
      end
      $display("summary: %0d tests, %0d checks, %0d errors, %0d commands, %0d replies",
               n_tests, checks, errors, n_cmd_acc, n_rsp);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

// File: vlog.f
+incdir+tests
verilog/fb_bus_pkg.sv
verilog/fb_map_pkg.sv
verilog/fb_addr_decode.sv
verilog/fb_router.sv
verilog/fb_resp_merge.sv
verilog/fb_ram_slave.sv
verilog/fb_reg_slave.sv
verilog/fb_fabric_top.sv
tests/fb_tb.sv

// File: Makefile
# Verilator flow for the frontend bus fabric

TOOL       = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP        = fb_tb
FLIST      = vlog.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = Something failed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(wildcard verilog/*.sv) $(wildcard tests/*.sv tests/*.svh)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); exit $$rc
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
